/* Bender.yml */
package:
  name: cache_mem_port

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_line_pkg.sv
      - hw/arb_pkg.sv
      - hw/dfp_if.sv
      - hw/dfp_request_hold.sv
      - hw/cache_arbiter.sv
      - hw/cache_mem_port.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/arb_checker.sv
      - testbench/tb_cache_mem_port.sv

/* cache_mem_port.f */
+incdir+hw
hw/mem_line_pkg.sv
hw/arb_pkg.sv
hw/dfp_if.sv
hw/dfp_request_hold.sv
hw/cache_arbiter.sv
hw/cache_mem_port.sv
testbench/arb_checker.sv
testbench/tb_cache_mem_port.sv

/* hw/arb_macros.svh */
`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

// width of a byte address on the memory side
`define ADDR_W 32

// one cache line moves as a single 256-bit beat
`define LINE_W 256

// low address bits that are always zero for a line address
`define LINE_ALIGN 5

`endif

/* hw/arb_pkg.sv */
package arb_pkg;

    // grant FSM states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        SERVE_I = 2'd1,
        SERVE_D = 2'd2
    } arb_state_t;

    // which slot a grant goes to
    typedef enum logic {
        CL_I = 1'b0,
        CL_D = 1'b1
    } client_t;

endpackage : arb_pkg

/* hw/cache_arbiter.sv */
`timescale 1ns/100ps
`include "arb_macros.svh"

module cache_arbiter
(
    input  logic                clk,
    input  logic                rst,

    dfp_if.arb                  port_i,
    dfp_if.arb                  port_d,

    output mem_line_pkg::addr_t o_mem_addr,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output mem_line_pkg::line_t o_mem_wdata,
    input  mem_line_pkg::line_t i_mem_rdata,
    input  logic                i_mem_resp
);
    import mem_line_pkg::*;
    import arb_pkg::*;

    arb_state_t state;
    arb_state_t state_next;
    logic       owed_i;
    logic       owed_next;
    logic       grant;
    client_t    pick;
    addr_t      grant_addr;
    logic       grant_write;

    always_comb
    begin
        state_next  = state;
        owed_next   = owed_i;
        grant       = 1'b0;
        pick        = CL_I;
        port_i.done = 1'b0;
        port_d.done = 1'b0;

        unique case (state)
            IDLE:
            begin
                // an instruction left waiting by a data transfer goes first
                if (owed_i && port_i.pending)
                begin
                    grant = 1'b1;
                    pick  = CL_I;
                end
                else if (port_d.pending)
                begin
                    grant = 1'b1;
                    pick  = CL_D;
                end
                else if (port_i.pending)
                begin
                    grant = 1'b1;
                    pick  = CL_I;
                end

                if (grant)
                begin
                    state_next = (pick == CL_D) ? SERVE_D : SERVE_I;
                    owed_next  = (pick == CL_D) ? port_i.pending : 1'b0;
                end
            end

            SERVE_I:
            begin
                port_i.done = i_mem_resp;
                if (i_mem_resp)
                begin
                    state_next = IDLE;
                end
            end

            SERVE_D:
            begin
                port_d.done = i_mem_resp;
                // instruction that shows up mid-transfer is also owed
                if (port_i.pending)
                begin
                    owed_next = 1'b1;
                end
                if (i_mem_resp)
                begin
                    state_next = IDLE;
                end
            end

            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    assign grant_addr  = (pick == CL_D) ? port_d.req.addr : port_i.req.addr;
    assign grant_write = (pick == CL_D) ? port_d.is_write : port_i.is_write;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= IDLE;
            owed_i      <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            owed_i <= owed_next;
            if (grant)
            begin
                o_mem_read  <= !grant_write;
                o_mem_write <= grant_write;
            end
            else if (state != IDLE && i_mem_resp)
            begin
                o_mem_read  <= 1'b0;
                o_mem_write <= 1'b0;
            end
        end
    end

    // address and write line stay put until the next grant
    always_ff @(posedge clk)
    begin
        if (grant)
        begin
            o_mem_addr  <= {grant_addr[`ADDR_W-1:`LINE_ALIGN], {`LINE_ALIGN{1'b0}}};
            o_mem_wdata <= port_d.req.wdata;
        end
    end

    // returned line goes to both slots and only the owner sees done
    assign port_i.rline = i_mem_rdata;
    assign port_d.rline = i_mem_rdata;

endmodule : cache_arbiter

/* hw/cache_mem_port.sv */
`timescale 1ns/100ps

module cache_mem_port
(
    input  logic                clk,
    input  logic                rst,

    // instruction cache side
    input  mem_line_pkg::addr_t i_ic_addr,
    input  logic                i_ic_read,
    output mem_line_pkg::line_t o_ic_rdata,
    output logic                o_ic_resp,

    // data cache side
    input  mem_line_pkg::addr_t i_dc_addr,
    input  logic                i_dc_read,
    input  logic                i_dc_write,
    input  mem_line_pkg::line_t i_dc_wdata,
    output mem_line_pkg::line_t o_dc_rdata,
    output logic                o_dc_resp,

    // shared memory port
    output mem_line_pkg::addr_t o_mem_addr,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output mem_line_pkg::line_t o_mem_wdata,
    input  mem_line_pkg::line_t i_mem_rdata,
    input  logic                i_mem_resp
);
    import mem_line_pkg::*;

    dfp_if #(.REQ_T(ireq_t)) if_i ();
    dfp_if #(.REQ_T(dreq_t)) if_d ();

    // instruction slot never writes
    dfp_request_hold #(.REQ_T(ireq_t)) u_hold_i
    (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_ic_read),
        .i_req   (ireq_t'{addr: i_ic_addr}),
        .i_write (1'b0),
        .o_resp  (o_ic_resp),
        .o_rline (o_ic_rdata),
        .port    (if_i.slot)
    );

    dfp_request_hold #(.REQ_T(dreq_t)) u_hold_d
    (
        .clk     (clk),
        .rst     (rst),
        .i_valid (i_dc_read || i_dc_write),
        .i_req   (dreq_t'{addr: i_dc_addr, write: i_dc_write, wdata: i_dc_wdata}),
        .i_write (i_dc_write),
        .o_resp  (o_dc_resp),
        .o_rline (o_dc_rdata),
        .port    (if_d.slot)
    );

    cache_arbiter u_arb
    (
        .clk         (clk),
        .rst         (rst),
        .port_i      (if_i.arb),
        .port_d      (if_d.arb),
        .o_mem_addr  (o_mem_addr),
        .o_mem_read  (o_mem_read),
        .o_mem_write (o_mem_write),
        .o_mem_wdata (o_mem_wdata),
        .i_mem_rdata (i_mem_rdata),
        .i_mem_resp  (i_mem_resp)
    );

endmodule : cache_mem_port

/* hw/dfp_if.sv */
`timescale 1ns/100ps

interface dfp_if
#(
    parameter type REQ_T = mem_line_pkg::ireq_t
);
    import mem_line_pkg::*;

    // slot has a captured request waiting for or being served by memory
    logic  pending;
    REQ_T  req;
    logic  is_write;

    // one-cycle pulse from the arbiter when memory answers this slot
    logic  done;
    line_t rline;

    modport slot
    (
        output pending,
        output req,
        output is_write,
        input  done,
        input  rline
    );

    modport arb
    (
        input  pending,
        input  req,
        input  is_write,
        output done,
        output rline
    );

endinterface : dfp_if

/* hw/dfp_request_hold.sv */
`timescale 1ns/100ps

module dfp_request_hold
#(
    parameter type REQ_T = mem_line_pkg::ireq_t
)
(
    input  logic                clk,
    input  logic                rst,

    input  logic                i_valid,
    input  REQ_T                i_req,
    input  logic                i_write,
    output logic                o_resp,
    output mem_line_pkg::line_t o_rline,

    dfp_if.slot                 port
);

    logic pending;
    logic blocked;
    logic capture;
    logic write_q;
    REQ_T req_q;

    // the client keeps its level up until after it sees resp,
    // so a finished slot stays blocked until that level goes away
    assign capture = i_valid && !pending && !blocked;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending <= 1'b0;
            blocked <= 1'b0;
            o_resp  <= 1'b0;
        end
        else
        begin
            o_resp <= port.done;

            if (port.done)
            begin
                pending <= 1'b0;
                blocked <= 1'b1;
            end
            else if (capture)
            begin
                pending <= 1'b1;
            end
            else if (blocked && !i_valid)
            begin
                blocked <= 1'b0;
            end
        end
    end

    // held payload and returned line
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            req_q   <= i_req;
            write_q <= i_write;
        end
        if (port.done)
        begin
            o_rline <= port.rline;
        end
    end

    assign port.pending  = pending;
    assign port.req      = req_q;
    assign port.is_write = write_q;

endmodule : dfp_request_hold

/* hw/mem_line_pkg.sv */
`include "arb_macros.svh"

package mem_line_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`LINE_W-1:0] line_t;

    // instruction side only ever reads, so the address is all it carries
    typedef struct packed {
        addr_t addr;
    } ireq_t;

    // data side request whose write line only matters when write is set
    typedef struct packed {
        addr_t addr;
        logic  write;
        line_t wdata;
    } dreq_t;

endpackage : mem_line_pkg

/* testbench/arb_checker.sv */
`timescale 1ns/100ps
`include "arb_macros.svh"

module arb_checker
(
    input  logic                clk,
    input  logic                rst,
    input  logic                i_ic_read,
    input  mem_line_pkg::addr_t i_ic_addr,
    input  mem_line_pkg::line_t i_ic_rdata,
    input  logic                i_ic_resp,
    input  logic                i_dc_read,
    input  logic                i_dc_write,
    input  mem_line_pkg::addr_t i_dc_addr,
    input  mem_line_pkg::line_t i_dc_wdata,
    input  mem_line_pkg::line_t i_dc_rdata,
    input  logic                i_dc_resp,
    input  mem_line_pkg::addr_t i_mem_addr,
    input  logic                i_mem_read,
    input  logic                i_mem_write,
    input  mem_line_pkg::line_t i_mem_wdata,
    input  logic                i_mem_resp,
    input  logic                i_test_end,
    input  int                  i_test_idx,
    input  logic [5:0]          i_exp_order,
    output int                  o_errors,
    output int                  o_passed
);
    import mem_line_pkg::*;

    localparam logic [1:0] CODE_I = 2'd1;
    localparam logic [1:0] CODE_D = 2'd2;

    // lines written so far, in order, so the latest write wins
    addr_t      wr_addr [$];
    line_t      wr_line [$];
    int         errors = 0;
    int         passed = 0;
    int         test_errs = 0;
    int         n_got = 0;
    logic [5:0] got_order = '0;
    logic       ic_lvl_q, dc_lvl_q, ic_out, dc_out, seen_req;
    addr_t      ic_addr_q, dc_addr_q;
    logic       dc_wr_q;
    line_t      dc_wdata_q;
    // last finished memory transfer
    addr_t      xfer_addr;
    logic       xfer_wr;
    line_t      xfer_wdata;
    // memory port as sampled at the previous edge
    logic       act_q, resp_q, rd_q, wr_q;
    addr_t      addr_q;
    line_t      wdata_q;

    function automatic addr_t line_base(input addr_t a);
        return (a >> `LINE_ALIGN) << `LINE_ALIGN;
    endfunction

    // unwritten lines hold a pattern made from the line address
    function automatic line_t expected_line(input addr_t base);
        line_t l;
        int    w;
        int    k;
        for (w = 0; w < 8; w++)
            l[w*32 +: 32] = (base + w * 32'h1000_0001) ^ 32'h5A5A_0000;
        for (k = 0; k < wr_addr.size(); k++)
            if (wr_addr[k] == base)
                l = wr_line[k];
        return l;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("** Error @ %0t: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic record_grant(input logic [1:0] code);
        if (n_got >= 3)
            report_mismatch("more than three grants in one test");
        else
            got_order[n_got*2 +: 2] = code;
        n_got++;
    endtask

    task automatic check_transfer(input string who, input addr_t a, input logic wr,
                                  input line_t wdata, input line_t rdata);
        if (xfer_addr !== line_base(a) || xfer_wr !== wr)
            report_mismatch($sformatf("%s served at %h write %b", who, xfer_addr, xfer_wr));
        if (wr && xfer_wdata !== wdata)
            report_mismatch($sformatf("%s write line differs on memory", who));
        if (!wr && rdata !== expected_line(line_base(a)))
            report_mismatch($sformatf("%s read of %h returned a wrong line", who, a));
        if (wr)
        begin
            wr_addr.push_back(line_base(a));
            wr_line.push_back(wdata);
        end
    endtask

    task automatic finish_test();
        if (got_order !== i_exp_order)
            report_mismatch($sformatf("grant order %b, expected %b", got_order, i_exp_order));
        if (test_errs == 0)
        begin
            passed++;
            $display("test %0d: ok", i_test_idx);
        end
        else
            $display("test %0d: failed with %0d errors", i_test_idx, test_errs);
        test_errs = 0;
        n_got = 0;
        got_order = '0;
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            ic_lvl_q = 1'b0;
            dc_lvl_q = 1'b0;
            ic_out   = 1'b0;
            dc_out   = 1'b0;
            seen_req = 1'b0;
            act_q    = 1'b0;
            resp_q   = 1'b0;
        end
        else
        begin
            if (!seen_req && (i_mem_read || i_mem_write || i_ic_resp || i_dc_resp))
                report_mismatch("control output high before the first request");
            if (i_mem_read && i_mem_write)
                report_mismatch("memory read and write high together");
            if (act_q && !resp_q && {i_mem_addr, i_mem_read, i_mem_write, i_mem_wdata}
                    !== {addr_q, rd_q, wr_q, wdata_q})
                report_mismatch("memory request changed before resp");

            if (i_ic_resp)
            begin
                if (!ic_out)
                    report_mismatch("instruction resp without a request");
                ic_out = 1'b0;
                record_grant(CODE_I);
                check_transfer("instruction", ic_addr_q, 1'b0, '0, i_ic_rdata);
            end
            if (i_dc_resp)
            begin
                if (!dc_out)
                    report_mismatch("data resp without a request");
                dc_out = 1'b0;
                record_grant(CODE_D);
                check_transfer("data", dc_addr_q, dc_wr_q, dc_wdata_q, i_dc_rdata);
            end
            if (i_mem_resp)
            begin
                xfer_addr  = i_mem_addr;
                xfer_wr    = i_mem_write;
                xfer_wdata = i_mem_wdata;
            end

            // a rising client level is a new request
            if (i_ic_read && !ic_lvl_q)
            begin
                seen_req  = 1'b1;
                ic_out    = 1'b1;
                ic_addr_q = i_ic_addr;
            end
            if ((i_dc_read || i_dc_write) && !dc_lvl_q)
            begin
                seen_req   = 1'b1;
                dc_out     = 1'b1;
                dc_addr_q  = i_dc_addr;
                dc_wr_q    = i_dc_write;
                dc_wdata_q = i_dc_wdata;
            end
            ic_lvl_q = i_ic_read;
            dc_lvl_q = i_dc_read || i_dc_write;

            act_q   = i_mem_read || i_mem_write;
            resp_q  = i_mem_resp;
            rd_q    = i_mem_read;
            wr_q    = i_mem_write;
            addr_q  = i_mem_addr;
            wdata_q = i_mem_wdata;

            if (i_test_end)
                finish_test();
        end
    end

    assign o_errors = errors;
    assign o_passed = passed;

endmodule : arb_checker

/* testbench/tb_cache_mem_port.sv */
`timescale 1ns/100ps

module tb_cache_mem_port;
    import mem_line_pkg::*;

    localparam int NUM_ROWS   = 8;
    localparam int MAX_CYCLES = NUM_ROWS * 20 + 50;
    localparam logic [1:0] RD = 2'd1;
    localparam logic [1:0] WR = 2'd2;
    localparam logic [1:0] GI = 2'd1;
    localparam logic [1:0] GD = 2'd2;

    // d_op 0 means no data access
    // d_again repeats the data access as a read
    typedef struct packed {
        logic       i_en;
        addr_t      i_addr;
        logic [3:0] i_start;
        logic [1:0] d_op;
        addr_t      d_addr;
        logic [3:0] d_start;
        logic       d_again;
        logic [5:0] order;
    } row_t;

    logic       clk;
    logic       rst;
    addr_t      ic_addr;
    logic       ic_read;
    line_t      ic_rdata;
    logic       ic_resp;
    addr_t      dc_addr;
    logic       dc_read;
    logic       dc_write;
    line_t      dc_wdata;
    line_t      dc_rdata;
    logic       dc_resp;
    addr_t      mem_addr;
    logic       mem_read;
    logic       mem_write;
    line_t      mem_wdata;
    line_t      mem_rdata;
    logic       mem_resp;
    logic       test_end;
    int         test_idx;
    logic [5:0] exp_order;
    int         errors;
    int         passed;
    int         cycles = 0;
    row_t       tbl [0:NUM_ROWS-1];
    addr_t      store_addr [$];
    line_t      store_line [$];

    cache_mem_port DUT
    (
        .clk         (clk),
        .rst         (rst),
        .i_ic_addr   (ic_addr),
        .i_ic_read   (ic_read),
        .o_ic_rdata  (ic_rdata),
        .o_ic_resp   (ic_resp),
        .i_dc_addr   (dc_addr),
        .i_dc_read   (dc_read),
        .i_dc_write  (dc_write),
        .i_dc_wdata  (dc_wdata),
        .o_dc_rdata  (dc_rdata),
        .o_dc_resp   (dc_resp),
        .o_mem_addr  (mem_addr),
        .o_mem_read  (mem_read),
        .o_mem_write (mem_write),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata),
        .i_mem_resp  (mem_resp)
    );

    arb_checker u_checker
    (
        .clk         (clk),
        .rst         (rst),
        .i_ic_read   (ic_read),
        .i_ic_addr   (ic_addr),
        .i_ic_rdata  (ic_rdata),
        .i_ic_resp   (ic_resp),
        .i_dc_read   (dc_read),
        .i_dc_write  (dc_write),
        .i_dc_addr   (dc_addr),
        .i_dc_wdata  (dc_wdata),
        .i_dc_rdata  (dc_rdata),
        .i_dc_resp   (dc_resp),
        .i_mem_addr  (mem_addr),
        .i_mem_read  (mem_read),
        .i_mem_write (mem_write),
        .i_mem_wdata (mem_wdata),
        .i_mem_resp  (mem_resp),
        .i_test_end  (test_end),
        .i_test_idx  (test_idx),
        .i_exp_order (exp_order),
        .o_errors    (errors),
        .o_passed    (passed)
    );

    function automatic logic [5:0] grant_seq(input logic [1:0] a, input logic [1:0] b,
                                             input logic [1:0] c);
        return {c, b, a};
    endfunction

    // backing memory content for a line that was never written
    function automatic line_t fill_line(input addr_t a);
        line_t l;
        int    w;
        for (w = 0; w < 8; w++)
            l[w*32 +: 32] = (a + w * 32'h1000_0001) ^ 32'h5A5A_0000;
        return l;
    endfunction

    function automatic line_t stored_line(input addr_t a);
        line_t l;
        int    k;
        l = fill_line(a);
        for (k = 0; k < store_addr.size(); k++)
            if (store_addr[k] == a)
                l = store_line[k];
        return l;
    endfunction

    function automatic line_t random_line();
        line_t l;
        int    w;
        for (w = 0; w < 8; w++)
            l[w*32 +: 32] = $urandom;
        return l;
    endfunction

    task automatic set_row(input int n, input logic ie, input addr_t ia, input int is,
                           input logic [1:0] op, input addr_t da, input int ds,
                           input logic again, input logic [5:0] ord);
        tbl[n] = {ie, ia, is[3:0], op, da, ds[3:0], again, ord};
    endtask

    // drives one table row and waits for every client resp it should bring
    task automatic run_row(input int r);
        int   c;
        int   i_left;
        int   d_left;
        int   d_raise;
        logic i_drop;
        logic d_drop;
        c        = 0;
        i_left   = tbl[r].i_en;
        d_left   = (tbl[r].d_op != 2'd0) + tbl[r].d_again;
        d_raise  = -1;
        i_drop   = 1'b0;
        d_drop   = 1'b0;
        ic_addr  = tbl[r].i_addr;
        dc_addr  = tbl[r].d_addr;
        dc_wdata = random_line();
        while (i_left > 0 || d_left > 0 || i_drop || d_drop)
        begin
            @(posedge clk);
            #1;
            // a client drops its level in the cycle after resp
            if (i_drop)
                ic_read = 1'b0;
            if (d_drop)
            begin
                dc_read  = 1'b0;
                dc_write = 1'b0;
                if (d_left > 0)
                    d_raise = c + 1;
            end
            i_drop = ic_resp;
            d_drop = dc_resp;
            i_left = i_left - ic_resp;
            d_left = d_left - dc_resp;
            if (tbl[r].i_en && c == tbl[r].i_start)
                ic_read = 1'b1;
            if (tbl[r].d_op != 2'd0 && c == tbl[r].d_start)
            begin
                dc_read  = (tbl[r].d_op == RD);
                dc_write = (tbl[r].d_op == WR);
            end
            if (c == d_raise)
                dc_read = 1'b1;
            c++;
        end
        test_idx  = r;
        exp_order = tbl[r].order;
        test_end  = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
        repeat (2) @(posedge clk);
        #1;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory model answers after 1 to 6 cycles
    initial
    begin
        int    lat;
        addr_t a;
        mem_resp  = 1'b0;
        mem_rdata = '0;
        forever
        begin
            @(posedge clk);
            #1;
            if (!rst && (mem_read || mem_write))
            begin
                lat = 1 + ($urandom % 6);
                repeat (lat - 1)
                begin
                    @(posedge clk);
                    #1;
                end
                a = mem_addr;
                if (mem_write)
                begin
                    store_addr.push_back(a);
                    store_line.push_back(mem_wdata);
                end
                else
                    mem_rdata = stored_line(a);
                mem_resp = 1'b1;
                @(posedge clk);
                #1;
                mem_resp = 1'b0;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        int r;
        rst       = 1'b1;
        ic_addr   = '0;
        ic_read   = 1'b0;
        dc_addr   = '0;
        dc_read   = 1'b0;
        dc_write  = 1'b0;
        dc_wdata  = '0;
        test_end  = 1'b0;
        test_idx  = 0;
        exp_order = '0;
        void'($urandom(98));

        //      instr en, addr,   start, data op, addr,       start, again, grant order
        set_row(0, 1, 32'h0000_1000, 0, 2'd0, 32'h0,        0, 0, grant_seq(GI, 0, 0));
        set_row(1, 0, 32'h0,         0, WR,   32'h0000_2000, 0, 0, grant_seq(GD, 0, 0));
        set_row(2, 0, 32'h0,         0, RD,   32'h0000_2000, 0, 0, grant_seq(GD, 0, 0));
        set_row(3, 1, 32'h0000_3000, 0, RD,   32'h0000_4000, 0, 0, grant_seq(GD, GI, 0));
        set_row(4, 1, 32'h0000_5000, 0, RD,   32'h0000_6000, 3, 0, grant_seq(GI, GD, 0));
        set_row(5, 1, 32'h0000_8000, 2, WR,   32'h0000_7000, 0, 1, grant_seq(GD, GI, GD));
        set_row(6, 1, 32'h0000_9014, 1, RD,   32'h0000_A008, 0, 0, grant_seq(GD, GI, 0));
        set_row(7, 1, 32'h0000_7000, 0, 2'd0, 32'h0,        0, 0, grant_seq(GI, 0, 0));

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        for (r = 0; r < NUM_ROWS; r++)
            run_row(r);

        $display("%0d of %0d tests passed, %0d errors", passed, NUM_ROWS, errors);
        if (errors == 0 && passed == NUM_ROWS)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : tb_cache_mem_port
